// ==== i2c_cfg.svh ====
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// system clocks per quarter of an scl bit, so one bit takes four times this
`define I2C_CLK_DIV 5

// entries in each of the transmit and receive queues
`define I2C_QUEUE_DEPTH 8

`define I2C_ADDR_W 7    // 7-bit target address
`define I2C_BYTE_W 8    // one data byte on the bus and on the register port
`define I2C_CNT_W 4     // write and read byte counts, one nibble each in the command byte
`define I2C_WB_ADR_W 2  // four registers behind the wishbone port

`endif

// ==== i2c_bus_pkg.sv ====
`include "i2c_cfg.svh"

package i2c_bus_pkg;

    // one byte as it is shifted over sda
    typedef logic [`I2C_BYTE_W-1:0] data_byte_t;

    // transaction sequencer states
    typedef enum logic [3:0] {
        seq_idle,       // bus idle, waiting for a command
        seq_start,      // pull sda low while scl is high
        seq_address,    // shift out the address and r/w bit
        seq_write,      // shift out one byte from the transmit queue
        seq_ack_check,  // sda released, peripheral acknowledge sampled
        seq_read,       // shift in one byte from the peripheral
        seq_master_ack, // master ack, or nack on the final byte
        seq_restart,    // repeated start between the write and read halves
        seq_stop        // sda low, then released while scl is high
    } seq_state_e;

    // quarter phases of one scl bit, in the order the generator steps through them
    typedef enum logic [1:0] {
        low_mid,  // scl low, sda may change here
        rise,     // scl goes high
        high_mid, // scl high, sda sampled here, start and stop made here
        fall      // scl goes low
    } scl_phase_e;

endpackage

// ==== i2c_reg_pkg.sv ====
`include "i2c_cfg.svh"

package i2c_reg_pkg;

    // register offsets on the wishbone port
    typedef enum logic [`I2C_WB_ADR_W-1:0] {
        reg_target     = 'd0, // target address, read and write
        reg_tx_data    = 'd1, // write only, every write pushes one byte
        reg_cmd_status = 'd2, // command on write, status on read
        reg_rx_data    = 'd3  // read only, every read pops one entry
    } reg_addr_e;

    // bit positions inside the status byte
    typedef enum int unsigned {
        stat_busy      = 0,
        stat_ack_error = 1, // sticky until the next command
        stat_tx_full   = 2,
        stat_rx_empty  = 3,
        stat_rx_last   = 4  // head of the receive queue is the final byte of a transaction
    } status_bit_e;

    // one receive queue entry
    typedef struct packed {
        logic                    last; // set on the byte that the master nacked
        i2c_bus_pkg::data_byte_t data;
    } rx_entry_t;

endpackage

// ==== i2c_queue.sv ====
`timescale 1ns/100ps

module i2c_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     full,
    output logic     empty
);
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;  // one bit wider so that a full queue can be told from an empty one
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // a push into a full queue is lost
    assign do_pop  = pop && !empty;  // a pop from an empty queue does nothing
    assign full    = count == (PTR_W + 1)'(DEPTH);
    assign empty   = count == '0;
    assign rdata   = mem[rd_ptr];    // head entry, only meaningful while not empty

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // depth need not be 2^n
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push != do_pop) begin
                count <= do_push ? count + 1'b1 : count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// ==== i2c_scl_gen.sv ====
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_scl_gen (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    scl_run,
    output logic                    scl,
    output logic                    tick,
    output i2c_bus_pkg::scl_phase_e phase
);
    localparam int DIV_W = $clog2(`I2C_CLK_DIV + 1);

    logic [DIV_W-1:0] div_cnt; // cycles spent in the present quarter

    // scl is high for the two quarters around high_mid and low for the rest
    assign scl = (phase == i2c_bus_pkg::rise) || (phase == i2c_bus_pkg::high_mid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            phase   <= i2c_bus_pkg::high_mid; // idle bus rests with scl high
            tick    <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (!scl_run) begin
                // phase and level are held, the next quarter gets its full length on resume
                div_cnt <= '0;
            end else if (div_cnt == DIV_W'(`I2C_CLK_DIV - 1)) begin
                div_cnt <= '0;
                phase   <= i2c_bus_pkg::scl_phase_e'(phase + 2'd1); // fall wraps to low_mid
                tick    <= 1'b1;                                    // marks entry to the new phase
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== i2c_wb_regs.sv ====
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_wb_regs (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`I2C_WB_ADR_W-1:0] wb_adr,
    input  i2c_bus_pkg::data_byte_t wb_wdata,
    output i2c_bus_pkg::data_byte_t wb_rdata,
    output logic                    wb_ack,
    output logic                    tx_push,
    output i2c_bus_pkg::data_byte_t tx_wdata,
    input  logic                    tx_full,
    output logic                    rx_pop,
    input  i2c_reg_pkg::rx_entry_t  rx_rdata,
    input  logic                    rx_empty,
    output logic                    cmd_start,
    output logic [`I2C_ADDR_W-1:0]  target_addr,
    output logic [`I2C_CNT_W-1:0]   write_count,
    output logic [`I2C_CNT_W-1:0]   read_count,
    input  logic                    busy,
    input  logic                    ack_error
);
    logic                    req;      // a new access, accepted on the coming edge
    logic                    req_done; // access answered, waiting for stb to drop
    logic                    wr_req;
    logic                    rd_req;
    i2c_bus_pkg::data_byte_t status;
    i2c_bus_pkg::data_byte_t rd_mux;

    assign req    = wb_cyc && wb_stb && !req_done;
    assign wr_req = req && wb_we;
    assign rd_req = req && !wb_we;

    // queue strobes act on the same edge that raises wb_ack
    assign tx_push  = wr_req && wb_adr == i2c_reg_pkg::reg_tx_data;
    assign tx_wdata = wb_wdata;
    assign rx_pop   = rd_req && wb_adr == i2c_reg_pkg::reg_rx_data;

    always_comb begin
        status = '0;
        status[i2c_reg_pkg::stat_busy]      = busy;
        status[i2c_reg_pkg::stat_ack_error] = ack_error;
        status[i2c_reg_pkg::stat_tx_full]   = tx_full;
        status[i2c_reg_pkg::stat_rx_empty]  = rx_empty;
        status[i2c_reg_pkg::stat_rx_last]   = !rx_empty && rx_rdata.last; // head entry only
    end

    always_comb begin
        case (wb_adr)
            i2c_reg_pkg::reg_target:     rd_mux = i2c_bus_pkg::data_byte_t'(target_addr);
            i2c_reg_pkg::reg_cmd_status: rd_mux = status;
            i2c_reg_pkg::reg_rx_data:    rd_mux = rx_empty ? '0 : rx_rdata.data; // empty reads zero
            default:                     rd_mux = '0; // transmit data is write only
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack      <= 1'b0;
            req_done    <= 1'b0;
            cmd_start   <= 1'b0;
            target_addr <= '0;
            write_count <= '0;
            read_count  <= '0;
        end else begin
            wb_ack    <= req;                             // exactly one cycle per access
            req_done  <= wb_stb && (req_done || req);
            cmd_start <= 1'b0;
            if (wr_req && wb_adr == i2c_reg_pkg::reg_target) begin
                target_addr <= wb_wdata[`I2C_ADDR_W-1:0];
            end
            // a command while a transaction is running is dropped
            if (wr_req && wb_adr == i2c_reg_pkg::reg_cmd_status && !busy) begin
                write_count <= wb_wdata[`I2C_CNT_W-1:0];               // low nibble
                read_count  <= wb_wdata[2*`I2C_CNT_W-1:`I2C_CNT_W];    // high nibble
                cmd_start   <= 1'b1;
            end
        end
    end

    // read data is taken before the pop moves the receive queue on
    always_ff @(posedge clk) begin
        if (rd_req) begin
            wb_rdata <= rd_mux;
        end
    end

endmodule

// ==== i2c_sequencer.sv ====
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_sequencer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cmd_start,
    input  logic [`I2C_ADDR_W-1:0]  target_addr,
    input  logic [`I2C_CNT_W-1:0]   write_count,
    input  logic [`I2C_CNT_W-1:0]   read_count,
    output logic                    busy,
    output logic                    ack_error,
    output logic                    scl_run,
    input  logic                    tick,
    input  i2c_bus_pkg::scl_phase_e phase,
    output logic                    tx_pop,
    input  i2c_bus_pkg::data_byte_t tx_rdata,
    input  logic                    tx_empty,
    output logic                    rx_push,
    output i2c_reg_pkg::rx_entry_t  rx_wdata,
    input  logic                    rx_full,
    output logic                    sda_drive_low,
    input  logic                    sda_in
);
    i2c_bus_pkg::seq_state_e state;
    i2c_bus_pkg::data_byte_t shift_reg; // bits go out and come in msb first
    i2c_bus_pkg::data_byte_t tx_bits;
    logic [`I2C_ADDR_W-1:0]  addr_q;    // kept for the repeated start
    logic [`I2C_CNT_W-1:0]   wr_left;
    logic [`I2C_CNT_W-1:0]   rd_left;
    logic [3:0]              bit_cnt;
    logic                    reading;   // the address being sent carries the read bit
    logic                    paused;    // scl held in low_mid by a queue
    logic                    in_low;
    logic                    stall;
    logic                    ev_low;
    logic                    ev_high;

    assign in_low = phase == i2c_bus_pkg::low_mid;

    // a byte may only begin once its data or its receive space is there
    assign stall = in_low && bit_cnt == 4'd0 &&
                   ((state == i2c_bus_pkg::seq_write && tx_empty) ||
                    (state == i2c_bus_pkg::seq_read && rx_full));

    assign ev_low  = in_low && (tick || paused) && !stall; // sda changes here
    assign ev_high = tick && phase == i2c_bus_pkg::high_mid; // sda sampled here
    assign busy    = state != i2c_bus_pkg::seq_idle;
    assign scl_run = busy && !stall;

    // the first bit of a write byte comes straight from the queue head
    assign tx_bits = (state == i2c_bus_pkg::seq_write && bit_cnt == 4'd0) ? tx_rdata : shift_reg;
    assign tx_pop  = ev_low && state == i2c_bus_pkg::seq_write && bit_cnt == 4'd0;

    // the eighth bit is joined to the seven already shifted in
    assign rx_push       = ev_high && state == i2c_bus_pkg::seq_read && bit_cnt == 4'd7;
    assign rx_wdata.data = {shift_reg[`I2C_BYTE_W-2:0], sda_in};
    assign rx_wdata.last = rd_left == `I2C_CNT_W'(1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= i2c_bus_pkg::seq_idle;
            shift_reg     <= '0;
            addr_q        <= '0;
            wr_left       <= '0;
            rd_left       <= '0;
            bit_cnt       <= '0;
            reading       <= 1'b0;
            paused        <= 1'b0;
            ack_error     <= 1'b0;
            sda_drive_low <= 1'b0;
        end else begin
            paused <= in_low && (tick || paused) && stall;
            case (state)
                i2c_bus_pkg::seq_idle: begin
                    if (cmd_start) begin
                        addr_q    <= target_addr;
                        wr_left   <= write_count;
                        rd_left   <= read_count;
                        shift_reg <= {target_addr, 1'b0}; // the first address always writes
                        bit_cnt   <= '0;
                        reading   <= 1'b0;
                        ack_error <= 1'b0;                 // cleared only by a new command
                        state     <= i2c_bus_pkg::seq_start;
                    end
                end
                i2c_bus_pkg::seq_start: begin
                    sda_drive_low <= 1'b1; // scl is still high from idle, this is the start
                    state         <= i2c_bus_pkg::seq_address;
                end
                i2c_bus_pkg::seq_address, i2c_bus_pkg::seq_write: begin
                    if (ev_low && bit_cnt == 4'd8) begin
                        sda_drive_low <= 1'b0; // free the line for the peripheral acknowledge
                        bit_cnt       <= '0;
                        state         <= i2c_bus_pkg::seq_ack_check;
                    end else if (ev_low) begin
                        sda_drive_low <= !tx_bits[`I2C_BYTE_W-1];
                        shift_reg     <= tx_bits << 1;
                        bit_cnt       <= bit_cnt + 1'b1;
                        if (tx_pop) begin
                            wr_left <= wr_left - 1'b1;
                        end
                    end
                end
                i2c_bus_pkg::seq_ack_check: begin
                    if (ev_high) begin
                        if (sda_in) begin
                            ack_error <= 1'b1; // nack ends the transaction with a stop
                            state     <= i2c_bus_pkg::seq_stop;
                        end else if (reading) begin
                            state <= i2c_bus_pkg::seq_read;
                        end else if (wr_left != '0) begin
                            state <= i2c_bus_pkg::seq_write;
                        end else if (rd_left != '0) begin
                            state <= i2c_bus_pkg::seq_restart;
                        end else begin
                            state <= i2c_bus_pkg::seq_stop;
                        end
                    end
                end
                i2c_bus_pkg::seq_read: begin
                    if (ev_low) begin
                        sda_drive_low <= 1'b0; // the peripheral drives the data bits
                    end
                    if (ev_high) begin
                        shift_reg <= rx_wdata.data;
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (rx_push) begin
                            rd_left <= rd_left - 1'b1;
                            bit_cnt <= '0;
                            state   <= i2c_bus_pkg::seq_master_ack;
                        end
                    end
                end
                i2c_bus_pkg::seq_master_ack: begin
                    if (ev_low) begin
                        sda_drive_low <= rd_left != '0; // ack while bytes remain, nack the final one
                    end
                    if (ev_high) begin
                        state <= (rd_left != '0) ? i2c_bus_pkg::seq_read : i2c_bus_pkg::seq_stop;
                    end
                end
                i2c_bus_pkg::seq_restart: begin
                    if (ev_low) begin
                        sda_drive_low <= 1'b0; // sda must be high before scl rises
                    end
                    if (ev_high) begin
                        sda_drive_low <= 1'b1; // falling sda under high scl, repeated start
                        shift_reg     <= {addr_q, 1'b1};
                        reading       <= 1'b1;
                        state         <= i2c_bus_pkg::seq_address;
                    end
                end
                i2c_bus_pkg::seq_stop: begin
                    if (ev_low) begin
                        sda_drive_low <= 1'b1;
                    end
                    if (ev_high) begin
                        sda_drive_low <= 1'b0; // rising sda under high scl, the stop
                        state         <= i2c_bus_pkg::seq_idle;
                    end
                end
                default: state <= i2c_bus_pkg::seq_idle;
            endcase
        end
    end

endmodule

// ==== i2c_master_top.sv ====
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_master_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`I2C_WB_ADR_W-1:0] wb_adr,
    input  i2c_bus_pkg::data_byte_t wb_wdata,
    output i2c_bus_pkg::data_byte_t wb_rdata,
    output logic                    wb_ack,
    output logic                    scl,
    output logic                    sda_drive_low,
    input  logic                    sda_in
);
    logic                    tx_push, tx_pop, tx_full, tx_empty;
    i2c_bus_pkg::data_byte_t tx_wdata, tx_rdata;
    logic                    rx_push, rx_pop, rx_full, rx_empty;
    i2c_reg_pkg::rx_entry_t  rx_wdata, rx_rdata;
    logic                    cmd_start, busy, ack_error;
    logic [`I2C_ADDR_W-1:0]  target_addr;
    logic [`I2C_CNT_W-1:0]   write_count, read_count;
    logic                    scl_run, tick;
    i2c_bus_pkg::scl_phase_e phase;

    i2c_wb_regs regs_i (.*);

    // bytes from software toward the bus
    i2c_queue #(
        .payload_t (i2c_bus_pkg::data_byte_t),
        .DEPTH     (`I2C_QUEUE_DEPTH)
    ) tx_queue_i (
        .clk, .arst_n, .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
        .rdata(tx_rdata), .full(tx_full), .empty(tx_empty)
    );

    // received bytes with their last flag
    i2c_queue #(
        .payload_t (i2c_reg_pkg::rx_entry_t),
        .DEPTH     (`I2C_QUEUE_DEPTH)
    ) rx_queue_i (
        .clk, .arst_n, .push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
        .rdata(rx_rdata), .full(rx_full), .empty(rx_empty)
    );

    i2c_scl_gen scl_gen_i (.*);

    i2c_sequencer seq_i (.*);

endmodule

// ==== i2c_slave_model.sv ====
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module i2c_slave_model #(
    parameter logic [`I2C_ADDR_W-1:0] ADDRESS = 7'h44
) (
    input  logic        scl,
    input  logic        sda,
    input  int unsigned reads_expected, // bytes per read phase, the master nacks the last one
    output logic        sda_low
);
    typedef enum {mode_idle, mode_addr, mode_write, mode_read} mode_e;

    mode_e       mode        = mode_idle;
    logic [7:0]  shift       = '0;
    logic [7:0]  rd_byte     = '0;   // shifted left as its bits go out
    int          bit_cnt     = 0;    // 8 means the acknowledge clock comes next
    int unsigned rd_index    = 0;
    logic        addressed   = 1'b0;
    logic        in_transfer = 1'b0; // a start was seen and no stop since
    logic        pull_low    = 1'b0;
    logic        scl_q       = 1'b1;
    logic        sda_q       = 1'b1;

    // logs that the testbench reads back
    logic [7:0] written_q [$];  // data bytes taken in write mode
    logic [7:0] supplied_q [$]; // bytes driven in read mode
    logic [7:0] addr_log [$];   // every address byte with its r/w bit
    int         start_count   = 0;
    int         restart_count = 0;
    int         stop_count    = 0;
    int         error_count   = 0;

    assign sda_low = pull_low;

    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
        if (scl && scl_q && sda_q && !sda) begin
            // start is only legal in the high half of the first clock of a byte,
            // so the rising edge before it has already been counted as one bit
            assert (mode == mode_idle || bit_cnt == 1) else begin
                $display("%0t ns: start condition in the middle of a byte", $time);
                error_count++;
            end
            if (in_transfer) begin
                restart_count++; // no stop in between, so this is a repeated start
            end
            start_count++;
            in_transfer = 1'b1;
            mode        = mode_addr;
            bit_cnt     = 0;
        end else if (scl && scl_q && !sda_q && sda) begin
            // the stop sits on the first clock of a byte as well
            assert (mode == mode_idle || bit_cnt == 1) else begin
                $display("%0t ns: stop condition in the middle of a byte", $time);
                error_count++;
            end
            stop_count++;
            in_transfer = 1'b0;
            mode        = mode_idle;
            bit_cnt     = 0;
            pull_low    = 1'b0;
        end else if (scl && !scl_q && mode != mode_idle) begin
            if (bit_cnt < 8) begin
                shift = {shift[6:0], sda}; // msb first
                bit_cnt++;
                if (bit_cnt == 8 && mode == mode_addr) begin
                    addr_log.push_back(shift);
                    addressed = shift[7:1] == ADDRESS;
                end else if (bit_cnt == 8 && mode == mode_write) begin
                    written_q.push_back(shift);
                end
            end else begin
                bit_cnt = 0; // ninth clock of the byte
                if (mode == mode_read) begin
                    rd_index++;
                    // every byte but the last is acknowledged by the master
                    assert (!sda == (rd_index < reads_expected)) else begin
                        $display("[ERROR] %0t ns master_ack: got %0b, expected %0b",
                                 $time, !sda, rd_index < reads_expected);
                        error_count++;
                    end
                    if (sda) begin
                        mode = mode_idle; // nack, only a stop or start may follow
                    end
                end else if (mode == mode_addr) begin
                    rd_index = 0;
                    mode = !addressed ? mode_idle : (shift[0] ? mode_read : mode_write);
                end
            end
        end else if (!scl && scl_q && mode != mode_idle) begin
            if (bit_cnt == 8) begin
                // acknowledge slot, released in read mode for the master
                pull_low = (mode == mode_write) || (mode == mode_addr && addressed);
            end else if (mode == mode_read) begin
                if (bit_cnt == 0) begin
                    rd_byte = 8'($urandom);
                    supplied_q.push_back(rd_byte);
                end else begin
                    rd_byte = rd_byte << 1;
                end
                pull_low = !rd_byte[7];
            end else begin
                pull_low = 1'b0;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== tb_i2c_master.sv ====
`timescale 1ns/100ps
`include "i2c_cfg.svh"

module tb_i2c_master;
    localparam logic [`I2C_ADDR_W-1:0] SLAVE_ADDR = 7'h44;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`I2C_WB_ADR_W-1:0]  wb_adr;
    logic [`I2C_BYTE_W-1:0]    wb_wdata;
    logic [`I2C_BYTE_W-1:0]    wb_rdata;
    logic                      wb_ack;
    logic                      scl;
    logic                      dut_sda_low;
    logic                      slave_sda_low;
    wire                       sda;
    int unsigned               reads_expected;

    int test_errors        = 0;
    int total_errors       = 0;
    int tests_run          = 0;
    int tests_failed       = 0;
    int model_errors_seen  = 0;
    int w0, s0, a0, st0, rs0, sp0; // model log positions at the start of a test

    // open-drain line with a pull-up, low while either side pulls
    assign sda = !(dut_sda_low || slave_sda_low);

    i2c_master_top dut_i (
        .clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
        .scl, .sda_drive_low(dut_sda_low), .sda_in(sda)
    );

    i2c_slave_model #(.ADDRESS(SLAVE_ADDR)) slave_i (
        .scl, .sda, .reads_expected, .sda_low(slave_sda_low)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // one wishbone classic access, the acknowledge must come after one cycle and last one
    task automatic access_reg(input logic we, input logic [`I2C_WB_ADR_W-1:0] adr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wb_ack && waited < 8);
        if (!wb_ack) begin
            $display("%0t ns: register %0d gave no wishbone acknowledge in 8 cycles", $time, adr);
            test_errors++;
        end else begin
            check_value("wb_ack latency", waited, 1);
        end
        rdata  = wb_rdata; // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #2;
        check_value("wb_ack", 32'(wb_ack), 0);
    endtask

    task automatic write_reg(input logic [`I2C_WB_ADR_W-1:0] adr, input logic [7:0] data);
        logic [7:0] unused;
        access_reg(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [`I2C_WB_ADR_W-1:0] adr, output logic [7:0] data);
        access_reg(1'b0, adr, 8'h00, data);
    endtask

    task automatic check_status(input int busy, input int ack_error, input int rx_empty);
        logic [7:0] st;
        read_reg(i2c_reg_pkg::reg_cmd_status, st);
        check_value("status busy", 32'(st[i2c_reg_pkg::stat_busy]), busy);
        check_value("status ack_error", 32'(st[i2c_reg_pkg::stat_ack_error]), ack_error);
        check_value("status rx_empty", 32'(st[i2c_reg_pkg::stat_rx_empty]), rx_empty);
    endtask

    // polls status until the sequencer leaves busy
    task automatic wait_idle();
        logic [7:0] st;
        int         polls;
        polls = 0;
        read_reg(i2c_reg_pkg::reg_cmd_status, st);
        while (st[i2c_reg_pkg::stat_busy] && polls < 2000) begin
            read_reg(i2c_reg_pkg::reg_cmd_status, st);
            polls++;
        end
        if (st[i2c_reg_pkg::stat_busy]) begin
            $display("%0t ns: transaction still busy after %0d status polls", $time, polls);
            test_errors++;
        end
    endtask

    task automatic check_bus_idle();
        check_value("scl", 32'(scl), 1);
        check_value("sda", 32'(sda), 1);
    endtask

    task automatic mark_bus_log();
        w0  = slave_i.written_q.size();
        s0  = slave_i.supplied_q.size();
        a0  = slave_i.addr_log.size();
        st0 = slave_i.start_count;
        rs0 = slave_i.restart_count;
        sp0 = slave_i.stop_count;
    endtask

    // pops n entries and compares them with the bytes that the model drove
    task automatic expect_rx(input int n);
        logic [7:0] st;
        logic [7:0] rd;
        check_value("bytes supplied", slave_i.supplied_q.size() - s0, n);
        for (int i = 0; i < n; i++) begin
            read_reg(i2c_reg_pkg::reg_cmd_status, st);
            check_value("rx_last", 32'(st[i2c_reg_pkg::stat_rx_last]), (i == n - 1) ? 1 : 0);
            read_reg(i2c_reg_pkg::reg_rx_data, rd);
            check_value("rx_data", 32'(rd), 32'(slave_i.supplied_q[s0 + i]));
        end
    endtask

    task automatic finish_test(input string name);
        test_errors += slave_i.error_count - model_errors_seen; // model reports its own lines
        model_errors_seen = slave_i.error_count;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        logic [7:0] rd;
        logic [7:0] tx_bytes [3];
        void'($urandom(32'hb0a0));
        arst_n         = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_wdata       = '0;
        reads_expected = 0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        check_status(0, 0, 1); // idle after reset
        write_reg(i2c_reg_pkg::reg_target, 8'(SLAVE_ADDR));
        read_reg(i2c_reg_pkg::reg_target, rd);
        check_value("target_addr", 32'(rd), 32'(SLAVE_ADDR));
        finish_test("register access");

        mark_bus_log();
        for (int i = 0; i < 3; i++) begin
            tx_bytes[i] = 8'($urandom);
            write_reg(i2c_reg_pkg::reg_tx_data, tx_bytes[i]);
        end
        write_reg(i2c_reg_pkg::reg_cmd_status, 8'h03); // three writes, no reads
        wait_idle();
        check_status(0, 0, 1);
        check_bus_idle();
        check_value("address byte", 32'(slave_i.addr_log[a0]), 32'h88);
        check_value("bytes written", slave_i.written_q.size() - w0, 3);
        for (int i = 0; i < 3; i++) begin
            check_value("written byte", 32'(slave_i.written_q[w0 + i]), 32'(tx_bytes[i]));
        end
        check_value("starts", slave_i.start_count - st0, 1);
        check_value("stops", slave_i.stop_count - sp0, 1);
        finish_test("write transaction");

        mark_bus_log();
        reads_expected = 4;
        write_reg(i2c_reg_pkg::reg_cmd_status, 8'h40);
        wait_idle();
        check_status(0, 0, 0);
        expect_rx(4);
        check_status(0, 0, 1); // all four popped
        check_bus_idle();
        finish_test("read transaction");

        mark_bus_log();
        reads_expected = 2;
        tx_bytes[0]    = 8'($urandom);
        write_reg(i2c_reg_pkg::reg_tx_data, tx_bytes[0]);
        write_reg(i2c_reg_pkg::reg_cmd_status, 8'h21);
        wait_idle();
        check_status(0, 0, 0);
        check_value("written byte", 32'(slave_i.written_q[w0]), 32'(tx_bytes[0]));
        check_value("write address", 32'(slave_i.addr_log[a0]), 32'h88);
        check_value("read address", 32'(slave_i.addr_log[a0 + 1]), 32'h89);
        check_value("restarts", slave_i.restart_count - rs0, 1);
        check_value("stops", slave_i.stop_count - sp0, 1); // only the final stop
        expect_rx(2);
        check_bus_idle();
        finish_test("write then read");

        mark_bus_log();
        write_reg(i2c_reg_pkg::reg_target, 8'h45); // nobody answers here
        write_reg(i2c_reg_pkg::reg_cmd_status, 8'h10);
        wait_idle();
        check_status(0, 1, 1);
        check_value("nacked address", 32'(slave_i.addr_log[a0]), 32'h8a);
        check_value("stops", slave_i.stop_count - sp0, 1);
        check_bus_idle();
        write_reg(i2c_reg_pkg::reg_target, 8'(SLAVE_ADDR));
        write_reg(i2c_reg_pkg::reg_cmd_status, 8'h00); // address only, clears the error
        wait_idle();
        check_status(0, 0, 1);
        check_bus_idle();
        finish_test("address nack");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
i2c_bus_pkg.sv
i2c_reg_pkg.sv
i2c_queue.sv
i2c_scl_gen.sv
i2c_wb_regs.sv
i2c_sequencer.sv
i2c_master_top.sv
i2c_slave_model.sv
tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_i2c_master \
    -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
